// File: sens_parallel12_consts.svh
/* addresses, register offsets and set/clear field positions of the sensor port.
   each control field is a 2-bit pair: 11 sets, 10 clears, 0x keeps */
`ifndef SENS_PARALLEL12_CONSTS_SVH
`define SENS_PARALLEL12_CONSTS_SVH

`define SENS_IO_ADDR          16'h330 // block base on the command bus
`define SENS_IO_ADDR_MASK     16'h3f8 // eight local registers

`define SENS_REG_CTRL         3'd0 // reset pins
`define SENS_REG_STATUS       3'd1 // status mode and sequence
`define SENS_REG_JTAG         3'd2 // external fpga programming
`define SENS_REG_WIDTH        3'd3 // line width, 0 passes hact

`define SENS_CTRL_MRST        0
`define SENS_CTRL_ARST        2
`define SENS_CTRL_ARO         4

`define SENS_JTAG_TDI         0
`define SENS_JTAG_TMS         2
`define SENS_JTAG_TCK         4
`define SENS_JTAG_PROG        6
`define SENS_JTAG_PGMEN       8

`define SENS_CMD_BYTES        6  // AL AH D0 D1 D2 D3
`define SENS_LINE_WIDTH_BITS  16
`define SENS_PXD_BITS         12
`define SENS_STATUS_REG_ADDR  8'h31 // first byte of every status packet

`endif

// File: sens_parallel12_pkg.sv
/* shared types of the sensor port; widths come from the consts header */
`include "sens_parallel12_consts.svh"

package sens_parallel12_pkg;

    typedef logic [2:0]                       sens_addr_t;  // local register offset
    typedef logic [31:0]                      sens_data_t;  // command data word
    typedef logic [`SENS_LINE_WIDTH_BITS-1:0] line_width_t;
    typedef logic [`SENS_PXD_BITS-1:0]        pxd_t;

    typedef struct packed {
        logic xfpga_done; // mrst pin read back as DONE
        logic xfpga_tdo;  // pxd[1] in programming mode
        logic senspgm_in; // program pin probe
    } status_payload_t;

    // value 2 is not decoded and behaves as off
    typedef enum logic [1:0] {
        STATUS_OFF    = 2'd0,
        STATUS_SINGLE = 2'd1,
        STATUS_AUTO   = 2'd3
    } status_mode_e;

endpackage

// File: sens_pad_ctrl_if.sv
/* pin-control levels from the register block to the pad mux, all mclk registered */
`timescale 1ns/100ps

interface sens_pad_ctrl_if;

    logic imrst;      // sensor MRST level
    logic iarst;      // sensor ARST level
    logic iaro;       // sensor ARO level
    logic xpgmen;     // external fpga programming mode
    logic xfpga_prog; // PROG_B to the fpga
    logic xfpga_tck;
    logic xfpga_tms;
    logic xfpga_tdi;

    modport regs (output imrst, iarst, iaro, xpgmen, xfpga_prog, xfpga_tck, xfpga_tms, xfpga_tdi);
    modport pads (input  imrst, iarst, iaro, xpgmen, xfpga_prog, xfpga_tck, xfpga_tms, xfpga_tdi);

endinterface

// File: sens_cmd_deser.sv
/* byte-serial command receiver: stb comes with AL only, a new stb restarts assembly.
   cmd_we_o pulses one cycle after D3 is sampled, outputs hold until the next write */
`timescale 1ns/100ps
`include "sens_parallel12_consts.svh"

module sens_cmd_deser (
    input  logic                           mclk,
    input  logic                           rst,
    input  logic [7:0]                     cmd_ad_i,   // AL AH D0 D1 D2 D3
    input  logic                           cmd_stb_i,  // with AL
    output sens_parallel12_pkg::sens_addr_t cmd_a_o,
    output sens_parallel12_pkg::sens_data_t cmd_data_o,
    output logic                           cmd_we_o
);

    localparam int SR_BITS = 8 * `SENS_CMD_BYTES;

    logic [SR_BITS-1:0] sr;   // newest byte enters at the top
    logic [2:0]         cnt;  // bytes taken so far, 0 when idle
    logic               done; // full command in sr
    logic               addr_hit;

    assign addr_hit = (sr[15:0] & `SENS_IO_ADDR_MASK) == (`SENS_IO_ADDR & `SENS_IO_ADDR_MASK);

    always_ff @(posedge mclk) begin
        if (cmd_stb_i || (cnt != 3'd0)) begin
            sr <= {cmd_ad_i, sr[SR_BITS-1:8]}; // after six bytes AL sits at [7:0]
        end
        if (done) begin
            cmd_a_o    <= sr[2:0];         // low address bits select the register
            cmd_data_o <= sr[SR_BITS-1:16];
        end
    end

    always_ff @(posedge mclk or posedge rst) begin
        if (rst) begin
            cnt      <= '0;
            done     <= 1'b0;
            cmd_we_o <= 1'b0;
        end else begin
            if (cmd_stb_i) begin
                cnt <= 3'd1;                       // restart on any stb
            end else if (cnt == 3'(`SENS_CMD_BYTES - 1)) begin
                cnt <= 3'd0;                       // D3 taken
            end else if (cnt != 3'd0) begin
                cnt <= cnt + 3'd1;
            end
            done     <= !cmd_stb_i && (cnt == 3'(`SENS_CMD_BYTES - 1));
            cmd_we_o <= done && addr_hit;          // other blocks ignored
        end
    end

endmodule

// File: sens_io_regs.sv
/* register decode: strobes one cycle after we, pin levels one more, width after two.
   a width of zero selects the sensor hact as is */
`timescale 1ns/100ps
`include "sens_parallel12_consts.svh"

module sens_io_regs (
    input  logic                             mclk,
    input  logic                             rst,
    input  sens_parallel12_pkg::sens_addr_t  cmd_a_i,
    input  sens_parallel12_pkg::sens_data_t  cmd_data_i,
    input  logic                             cmd_we_i,
    sens_pad_ctrl_if.regs                    pad,
    output sens_parallel12_pkg::line_width_t line_width_m1_o, // regenerated hact length - 1
    output logic                             line_internal_o, // 1: regenerate hact
    output logic                             set_status_o,
    output logic [7:0]                       status_wd_o
);

    sens_parallel12_pkg::sens_data_t data_r; // last written word
    logic                            set_ctrl_r;
    logic                            set_jtag_r;
    logic [1:0]                      set_width_r; // two stages before the width lands

    // 11 sets, 10 clears, 0x keeps
    function automatic logic set_clr(input logic cur, input logic [1:0] code);
        return code[1] ? code[0] : cur;
    endfunction

    assign status_wd_o = data_r[7:0];

    always_ff @(posedge mclk) begin
        if (cmd_we_i) data_r <= cmd_data_i;
    end

    always_ff @(posedge mclk or posedge rst) begin
        if (rst) begin
            set_ctrl_r   <= 1'b0;
            set_jtag_r   <= 1'b0;
            set_status_o <= 1'b0;
            set_width_r  <= '0;
        end else begin
            set_ctrl_r   <= cmd_we_i && (cmd_a_i == `SENS_REG_CTRL);
            set_jtag_r   <= cmd_we_i && (cmd_a_i == `SENS_REG_JTAG);
            set_status_o <= cmd_we_i && (cmd_a_i == `SENS_REG_STATUS);
            set_width_r  <= {set_width_r[0], cmd_we_i && (cmd_a_i == `SENS_REG_WIDTH)};
        end
    end

    always_ff @(posedge mclk or posedge rst) begin
        if (rst) begin
            pad.imrst      <= 1'b0;
            pad.iarst      <= 1'b0;
            pad.iaro       <= 1'b0;
            pad.xpgmen     <= 1'b0;
            pad.xfpga_prog <= 1'b0;
            pad.xfpga_tck  <= 1'b0;
            pad.xfpga_tms  <= 1'b0;
            pad.xfpga_tdi  <= 1'b0;
        end else begin
            if (set_ctrl_r) begin
                pad.imrst <= set_clr(pad.imrst, data_r[`SENS_CTRL_MRST +: 2]);
                pad.iarst <= set_clr(pad.iarst, data_r[`SENS_CTRL_ARST +: 2]);
                pad.iaro  <= set_clr(pad.iaro,  data_r[`SENS_CTRL_ARO  +: 2]); // own enable
            end
            if (set_jtag_r) begin
                pad.xpgmen     <= set_clr(pad.xpgmen,     data_r[`SENS_JTAG_PGMEN +: 2]);
                pad.xfpga_prog <= set_clr(pad.xfpga_prog, data_r[`SENS_JTAG_PROG  +: 2]);
                pad.xfpga_tck  <= set_clr(pad.xfpga_tck,  data_r[`SENS_JTAG_TCK   +: 2]);
                pad.xfpga_tms  <= set_clr(pad.xfpga_tms,  data_r[`SENS_JTAG_TMS   +: 2]);
                pad.xfpga_tdi  <= set_clr(pad.xfpga_tdi,  data_r[`SENS_JTAG_TDI   +: 2]);
            end
        end
    end

    always_ff @(posedge mclk or posedge rst) begin
        if (rst) begin
            line_width_m1_o <= '0;
            line_internal_o <= 1'b0;
        end else if (set_width_r[1]) begin
            line_width_m1_o <= data_r[`SENS_LINE_WIDTH_BITS-1:0] - 1'b1;
            line_internal_o <= |data_r[`SENS_LINE_WIDTH_BITS-1:0]; // zero tested on 16 bits
        end
    end

endmodule

// File: sens_pad_mux.sv
/* sensor reset pins shared with fpga JTAG while xpgmen is high; pins follow levels
   combinationally. after programming the senspgm pin level is kept as a forced drive */
`timescale 1ns/100ps

module sens_pad_mux (
    input  logic                                 mclk,
    input  logic                                 rst,
    sens_pad_ctrl_if.pads                        pad,
    input  logic                                 mrst_i,       // DONE in programming mode
    output logic                                 mrst_o,
    output logic                                 mrst_oe_o,
    output logic                                 arst_o,
    output logic                                 aro_o,
    input  logic                                 senspgm_i,
    output logic                                 senspgm_o,
    output logic                                 senspgm_oe_o,
    output logic                                 pxd0_o,       // TDI in programming mode
    output logic                                 pxd0_oe_o,
    input  logic                                 pxd1_i,       // TDO in programming mode
    output sens_parallel12_pkg::status_payload_t payload_o
);

    logic [1:0] xpgmen_d;      // xpgmen history, 2'b10 marks the fall
    logic       force_senspgm; // probed pin level kept after programming

    assign aro_o     = pad.xpgmen ? pad.xfpga_tck : pad.iaro;
    assign arst_o    = pad.xpgmen ? pad.xfpga_tms : pad.iarst;
    assign mrst_o    = pad.imrst;
    assign mrst_oe_o = ~pad.xpgmen; // released to read DONE
    assign pxd0_o    = pad.xfpga_tdi;
    assign pxd0_oe_o = pad.xpgmen;

    assign senspgm_o    = pad.xpgmen ? ~pad.xfpga_prog : force_senspgm;
    assign senspgm_oe_o = pad.xpgmen | force_senspgm;

    assign payload_o.xfpga_done = mrst_i;
    assign payload_o.xfpga_tdo  = pxd1_i;
    assign payload_o.senspgm_in = senspgm_i;

    always_ff @(posedge mclk or posedge rst) begin
        if (rst) begin
            xpgmen_d      <= '0;
            force_senspgm <= 1'b0;
        end else begin
            xpgmen_d <= {xpgmen_d[0], pad.xpgmen};
            if (xpgmen_d == 2'b10) force_senspgm <= senspgm_i; // pin left floating then
        end
    end

endmodule

// File: sens_hact_regen.sv
/* two-stage pixel bus sampling; hact either passes through or is regenerated
   with the programmed width, starting on each sampled rising edge */
`timescale 1ns/100ps

module sens_hact_regen (
    input  logic                             mclk,
    input  logic                             rst,
    input  sens_parallel12_pkg::pxd_t        pxd_i,
    input  logic                             vact_i,
    input  logic                             hact_i,
    input  sens_parallel12_pkg::line_width_t line_width_m1_i,
    input  logic                             line_internal_i,
    output sens_parallel12_pkg::pxd_t        pxd_o,
    output logic                             vact_o,
    output logic                             hact_o
);

    sens_parallel12_pkg::pxd_t        pxd_r;  // input stage
    logic                             vact_r;
    logic                             hact_r; // sampled hact
    logic                             hact_d; // for edge detect
    sens_parallel12_pkg::line_width_t hact_cntr;

    always_ff @(posedge mclk) begin
        pxd_r <= pxd_i;
        pxd_o <= pxd_r;
    end

    always_ff @(posedge mclk or posedge rst) begin
        if (rst) begin
            vact_r    <= 1'b0;
            vact_o    <= 1'b0;
            hact_r    <= 1'b0;
            hact_d    <= 1'b0;
            hact_o    <= 1'b0;
            hact_cntr <= '0;
        end else begin
            vact_r <= vact_i;
            vact_o <= vact_r;
            hact_r <= hact_i;
            hact_d <= hact_r;
            if (hact_r && !hact_d) begin
                hact_o    <= 1'b1;            // line start
                hact_cntr <= line_width_m1_i;
            end else begin
                if (line_internal_i ? (hact_cntr == '0) : !hact_r) hact_o <= 1'b0;
                if (hact_o) hact_cntr <= hact_cntr - 1'b1;
            end
        end
    end

endmodule

// File: sens_status_gen.sv
/* status packets: address byte 'h31 between packets, then {seq, payload} after start.
   rq holds until start is seen; single mode sends once, auto on each payload change */
`timescale 1ns/100ps
`include "sens_parallel12_consts.svh"

module sens_status_gen (
    input  logic                                 mclk,
    input  logic                                 rst,
    input  logic                                 set_status_i,
    input  logic [7:0]                           status_wd_i,  // [1:0] mode, [6:2] seq
    input  sens_parallel12_pkg::status_payload_t payload_i,
    output logic [7:0]                           status_ad_o,
    output logic                                 status_rq_o,
    input  logic                                 status_start_i
);

    sens_parallel12_pkg::status_mode_e    mode;
    logic [4:0]                           seq;
    sens_parallel12_pkg::status_payload_t sent;      // payload of the last packet
    logic [7:0]                           data_byte;
    logic                                 data_phase; // cycle after start
    logic                                 start_edge;
    logic                                 new_mode;
    logic                                 need;

    assign start_edge = status_rq_o && status_start_i;
    assign new_mode   = set_status_i && (status_wd_i[0] == 1'b1); // single or auto, once on entry
    // auto compare is idle while a request is pending
    assign need = new_mode ||
                  ((mode == sens_parallel12_pkg::STATUS_AUTO) && !status_rq_o &&
                   (payload_i != sent));

    assign status_ad_o = data_phase ? data_byte : `SENS_STATUS_REG_ADDR;

    always_ff @(posedge mclk) begin
        if (start_edge) data_byte <= {seq, payload_i}; // payload latched on start
    end

    always_ff @(posedge mclk or posedge rst) begin
        if (rst) begin
            mode        <= sens_parallel12_pkg::STATUS_OFF;
            seq         <= '0;
            sent        <= '0;
            status_rq_o <= 1'b0;
            data_phase  <= 1'b0;
        end else begin
            status_rq_o <= need || (status_rq_o && !status_start_i);
            data_phase  <= start_edge;
            if (start_edge) sent <= payload_i;
            if (set_status_i) begin
                mode <= sens_parallel12_pkg::status_mode_e'(status_wd_i[1:0]); // 2 acts as off
                seq  <= status_wd_i[6:2];
            end else if (start_edge && (mode == sens_parallel12_pkg::STATUS_SINGLE)) begin
                mode <= sens_parallel12_pkg::STATUS_OFF;
            end
        end
    end

endmodule

// File: sens_parallel12.sv
/* control side of a 12-bit parallel sensor port on mclk; tristate pads are split
   into _o, _oe_o and _i, the pixel bus is sampled on mclk */
`timescale 1ns/100ps

module sens_parallel12 (
    input  logic                      mclk,
    input  logic                      rst,
    input  logic [7:0]                cmd_ad_i,
    input  logic                      cmd_stb_i,
    output logic [7:0]                status_ad_o,
    output logic                      status_rq_o,
    input  logic                      status_start_i,
    input  logic                      mrst_i,
    output logic                      mrst_o,
    output logic                      mrst_oe_o,
    output logic                      arst_o,
    output logic                      aro_o,
    input  logic                      senspgm_i,
    output logic                      senspgm_o,
    output logic                      senspgm_oe_o,
    output logic                      pxd0_o,
    output logic                      pxd0_oe_o,
    input  sens_parallel12_pkg::pxd_t pxd_i,
    input  logic                      vact_i,
    input  logic                      hact_i,
    output sens_parallel12_pkg::pxd_t pxd_o,
    output logic                      vact_o,
    output logic                      hact_o
);

    sens_parallel12_pkg::sens_addr_t      cmd_a;
    sens_parallel12_pkg::sens_data_t      cmd_data;
    logic                                 cmd_we;
    sens_parallel12_pkg::line_width_t     line_width_m1;
    logic                                 line_internal;
    logic                                 set_status;
    logic [7:0]                           status_wd;
    sens_parallel12_pkg::status_payload_t payload;

    sens_pad_ctrl_if pad_if ();

    sens_cmd_deser cmd_deser_i (
        .mclk, .rst, .cmd_ad_i, .cmd_stb_i,
        .cmd_a_o (cmd_a), .cmd_data_o (cmd_data), .cmd_we_o (cmd_we)
    );

    sens_io_regs io_regs_i (
        .mclk, .rst, .cmd_a_i (cmd_a), .cmd_data_i (cmd_data), .cmd_we_i (cmd_we),
        .pad (pad_if.regs),
        .line_width_m1_o (line_width_m1), .line_internal_o (line_internal),
        .set_status_o (set_status), .status_wd_o (status_wd)
    );

    sens_pad_mux pad_mux_i (
        .mclk, .rst, .pad (pad_if.pads),
        .mrst_i, .mrst_o, .mrst_oe_o, .arst_o, .aro_o,
        .senspgm_i, .senspgm_o, .senspgm_oe_o, .pxd0_o, .pxd0_oe_o,
        .pxd1_i (pxd_i[1]), // TDO shares the pixel bus
        .payload_o (payload)
    );

    sens_hact_regen hact_regen_i (
        .mclk, .rst, .pxd_i, .vact_i, .hact_i,
        .line_width_m1_i (line_width_m1), .line_internal_i (line_internal),
        .pxd_o, .vact_o, .hact_o
    );

    sens_status_gen status_gen_i (
        .mclk, .rst, .set_status_i (set_status), .status_wd_i (status_wd),
        .payload_i (payload), .status_ad_o, .status_rq_o, .status_start_i
    );

endmodule

// File: tb_sens_parallel12.sv
/* directed testbench: inputs driven on the rising edge, outputs sampled on the falling
   edge; fixed latencies come from the register pipeline, status waits for rq */
`timescale 1ns/100ps
`include "sens_parallel12_consts.svh"

module tb_sens_parallel12;

    localparam int CLK_PERIOD  = 4;
    localparam int N_TESTS     = 6;
    localparam int TEST_CYCLES = 2000; // hact lines are the longest test
    localparam logic [15:0] ADDR_CTRL   = `SENS_IO_ADDR | 16'(`SENS_REG_CTRL);
    localparam logic [15:0] ADDR_STATUS = `SENS_IO_ADDR | 16'(`SENS_REG_STATUS);
    localparam logic [15:0] ADDR_JTAG   = `SENS_IO_ADDR | 16'(`SENS_REG_JTAG);
    localparam logic [15:0] ADDR_WIDTH  = `SENS_IO_ADDR | 16'(`SENS_REG_WIDTH);

    logic                      mclk, rst;
    logic [7:0]                cmd_ad_i, status_ad_o;
    logic                      cmd_stb_i, status_rq_o, status_start_i;
    logic                      mrst_i, mrst_o, mrst_oe_o, arst_o, aro_o;
    logic                      senspgm_i, senspgm_o, senspgm_oe_o, pxd0_o, pxd0_oe_o;
    logic [`SENS_PXD_BITS-1:0] pxd_i, pxd_o;
    logic                      vact_i, hact_i, vact_o, hact_o;
    logic                      m_mrst, m_arst, m_aro; // expected pin levels
    int                        errors = 0;
    int                        timeouts = 0;
    int                        checks = 0;

    sens_parallel12 uut (.*);

    always #(CLK_PERIOD / 2) mclk = ~mclk;

    task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error at %0t ns: %s got %0h expected %0h", $time, what, got, exp);
        end
    endtask

    task automatic after_edges(input int n);
        repeat (n) @(posedge mclk);
        @(negedge mclk); // outputs settled
    endtask

    // returns on the edge that samples D3
    task automatic write_cmd(input logic [15:0] addr, input logic [31:0] data);
        logic [47:0] bytes;
        bytes = {data, addr}; // AL first
        for (int i = 0; i < `SENS_CMD_BYTES; i++) begin
            @(posedge mclk);
            cmd_stb_i <= (i == 0);
            cmd_ad_i  <= bytes[8*i +: 8];
        end
        @(posedge mclk);
        cmd_stb_i <= 1'b0;
        cmd_ad_i  <= 8'h00;
    endtask

    function automatic logic pair_level(input logic cur, input logic [1:0] code);
        if (code == 2'b11) return 1'b1;
        if (code == 2'b10) return 1'b0;
        return cur;
    endfunction

    // waits for rq, withholds start a random time, then reads the data byte
    task automatic run_packet(input logic [7:0] exp_byte, input string what);
        int wait_n;
        int hold;
        wait_n = 0;
        while (!status_rq_o && wait_n < 10) begin
            @(negedge mclk);
            wait_n++;
        end
        if (!status_rq_o) begin
            timeouts++;
            $display("%s: status request did not rise within 10 cycles", what);
            return;
        end
        check({what, " idle byte"}, status_ad_o, `SENS_STATUS_REG_ADDR);
        hold = $urandom_range(6, 0);
        repeat (hold) begin
            @(negedge mclk);
            check({what, " rq held"}, status_rq_o, 1);
            check({what, " idle byte held"}, status_ad_o, `SENS_STATUS_REG_ADDR);
        end
        @(posedge mclk);
        status_start_i <= 1'b1;
        @(posedge mclk);
        status_start_i <= 1'b0; // seen on this edge
        @(negedge mclk);
        check({what, " data byte"}, status_ad_o, exp_byte);
        check({what, " rq dropped"}, status_rq_o, 0);
        @(negedge mclk);
        check({what, " back to address"}, status_ad_o, `SENS_STATUS_REG_ADDR);
    endtask

    task automatic test_addr_filter;
        write_cmd(`SENS_IO_ADDR + 16'h8, 32'h3); // next block up
        after_edges(3);
        check("mrst after foreign write", mrst_o, 0);
        write_cmd(ADDR_CTRL, 32'h3);
        after_edges(2);
        check("mrst one cycle early", mrst_o, 0);
        after_edges(1); // 8 edges after stb
        check("mrst set", mrst_o, 1);
        m_mrst = 1'b1;
    endtask

    task automatic test_set_clear;
        logic [1:0]  c_mrst, c_arst, c_aro;
        logic [31:0] d;
        write_cmd(ADDR_CTRL, 32'h30); // aro only
        after_edges(3);
        m_aro = 1'b1;
        check("aro set", aro_o, 1);
        write_cmd(ADDR_CTRL, 32'h02); // mrst clear, aro code 00
        after_edges(3);
        m_mrst = 1'b0;
        check("aro kept on mrst write", aro_o, 1);
        check("mrst cleared", mrst_o, 0);
        repeat (12) begin
            c_mrst = 2'($urandom);
            c_arst = 2'($urandom);
            c_aro  = 2'($urandom);
            d = '0;
            d[`SENS_CTRL_MRST +: 2] = c_mrst;
            d[`SENS_CTRL_ARST +: 2] = c_arst;
            d[`SENS_CTRL_ARO  +: 2] = c_aro;
            write_cmd(ADDR_CTRL, d);
            m_mrst = pair_level(m_mrst, c_mrst);
            m_arst = pair_level(m_arst, c_arst);
            m_aro  = pair_level(m_aro, c_aro);
            after_edges(3);
            check("mrst pair", mrst_o, m_mrst);
            check("arst pair", arst_o, m_arst);
            check("aro pair", aro_o, m_aro);
        end
    endtask

    task automatic test_prog_mode;
        logic        tck, tms, tdi, prog, done, tdo;
        logic [4:0]  seq;
        logic [31:0] d;
        repeat (6) begin
            {tck, tms, tdi, prog} = 4'($urandom);
            d = '0;
            d[`SENS_JTAG_PGMEN +: 2] = 2'b11;
            d[`SENS_JTAG_PROG  +: 2] = {1'b1, prog};
            d[`SENS_JTAG_TCK   +: 2] = {1'b1, tck};
            d[`SENS_JTAG_TMS   +: 2] = {1'b1, tms};
            d[`SENS_JTAG_TDI   +: 2] = {1'b1, tdi};
            write_cmd(ADDR_JTAG, d);
            after_edges(3);
            check("aro as tck", aro_o, tck);
            check("arst as tms", arst_o, tms);
            check("pxd0 as tdi", pxd0_o, tdi);
            check("pxd0 driven", pxd0_oe_o, 1);
            check("mrst released", mrst_oe_o, 0);
            check("senspgm as inverse prog", senspgm_o, !prog);
        end
        {done, tdo} = 2'($urandom);
        seq = 5'($urandom);
        @(posedge mclk);
        mrst_i    <= done;
        pxd_i     <= {{(`SENS_PXD_BITS - 2){1'b0}}, tdo, 1'b0};
        senspgm_i <= 1'b0;
        write_cmd(ADDR_STATUS, {25'd0, seq, 2'b01}); // single
        run_packet({seq, done, tdo, 1'b0}, "done/tdo packet");
    endtask

    task automatic test_probe;
        logic        lvl;
        logic [31:0] d;
        lvl = 1'($urandom);
        repeat (2) begin
            d = '0;
            d[`SENS_JTAG_PGMEN +: 2] = 2'b11;
            write_cmd(ADDR_JTAG, d);
            after_edges(3);
            @(posedge mclk);
            senspgm_i <= lvl;
            d[`SENS_JTAG_PGMEN +: 2] = 2'b10;
            write_cmd(ADDR_JTAG, d);
            after_edges(5); // fall seen through the history, then latched
            check("senspgm oe after probe", senspgm_oe_o, lvl);
            check("senspgm level after probe", senspgm_o, lvl);
            check("pxd0 released after programming", pxd0_oe_o, 0);
            check("mrst driven after programming", mrst_oe_o, 1);
            lvl = !lvl;
        end
    endtask

    task automatic test_hact;
        logic [`SENS_PXD_BITS-1:0] pxd_h [0:63];
        logic                      vact_h [0:63];
        logic                      hact_h [0:63];
        int                        n, m, high, first;
        write_cmd(ADDR_WIDTH, 32'hffff_0000); // width 0, upper half is not part of it
        after_edges(4);
        for (int k = 0; k < 64; k++) begin
            @(posedge mclk);
            pxd_h[k]  = `SENS_PXD_BITS'($urandom);
            vact_h[k] = 1'($urandom);
            hact_h[k] = ($urandom % 4) != 0;
            pxd_i  <= pxd_h[k];
            vact_i <= vact_h[k];
            hact_i <= hact_h[k];
            @(negedge mclk);
            if (k >= 2) begin
                check("pxd delayed", pxd_o, pxd_h[k-2]);
                check("vact delayed", vact_o, vact_h[k-2]);
                check("hact passed", hact_o, hact_h[k-2]);
            end
        end
        @(posedge mclk);
        hact_i <= 1'b0;
        for (int line = 0; line < 6; line++) begin
            n = $urandom_range(40, 1);
            m = $urandom_range(60, 1); // sensor line length, ignored
            write_cmd(ADDR_WIDTH, 32'(n));
            after_edges(4);
            high  = 0;
            first = -1;
            for (int k = 0; k < m + n + 8; k++) begin
                @(posedge mclk);
                hact_i <= (k < m);
                @(negedge mclk);
                if (hact_o) begin
                    high++;
                    if (first < 0) first = k;
                end
            end
            check("regenerated line length", high, n);
            check("regenerated line start", first, 2);
        end
    endtask

    task automatic test_status;
        logic [4:0] seq;
        logic       done, pgm;
        seq = 5'($urandom);
        {done, pgm} = 2'($urandom);
        @(posedge mclk);
        mrst_i    <= done;
        senspgm_i <= pgm;
        pxd_i     <= '0;
        write_cmd(ADDR_STATUS, {25'd0, seq, 2'b01});
        run_packet({seq, done, 1'b0, pgm}, "single packet");
        seq = 5'($urandom);
        write_cmd(ADDR_STATUS, {25'd0, seq, 2'b11}); // auto, one packet on entry
        run_packet({seq, done, 1'b0, pgm}, "auto entry packet");
        @(posedge mclk);
        done = !done;
        mrst_i <= done;
        run_packet({seq, done, 1'b0, pgm}, "auto change packet");
        write_cmd(ADDR_STATUS, 32'd0);
    endtask

    initial begin : watchdog
        #(N_TESTS * TEST_CYCLES * CLK_PERIOD);
        $display("watchdog: run did not finish within %0d cycles", N_TESTS * TEST_CYCLES);
        $display("TESTS FAILED");
        $finish;
    end

    initial begin
        void'($urandom(32'h30e8a27c));
        mclk = 1'b0;
        rst = 1'b1;
        cmd_ad_i = 8'h00;
        cmd_stb_i = 1'b0;
        status_start_i = 1'b0;
        mrst_i = 1'b0;
        senspgm_i = 1'b0;
        pxd_i = '0;
        vact_i = 1'b0;
        hact_i = 1'b0;
        {m_mrst, m_arst, m_aro} = 3'b000;
        repeat (5) @(posedge mclk);
        rst <= 1'b0;
        test_addr_filter();
        test_set_clear();
        test_prog_mode();
        test_probe();
        test_hact();
        test_status();
        after_edges(4);
        $display("checks %0d, value errors %0d, timeouts %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: sens_parallel12.f
+incdir+.
sens_parallel12_pkg.sv
sens_pad_ctrl_if.sv
sens_cmd_deser.sv
sens_io_regs.sv
sens_pad_mux.sv
sens_hact_regen.sv
sens_status_gen.sv
sens_parallel12.sv
tb_sens_parallel12.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds and runs the sensor port testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing -Wno-fatal --top-module tb_sens_parallel12 \
        -f sens_parallel12.f -Mdir obj_dir; then
    echo "build failed"
    exit 1
fi

if ! ./obj_dir/Vtb_sens_parallel12 > "$LOG" 2>&1; then
    cat "$LOG"
    echo "simulation exited with an error status"
    exit 1
fi
cat "$LOG"

if grep -qx "TESTS PASSED" "$LOG"; then
    exit 0
fi
exit 1
